// ==== src/seg_pkg.sv ====
package seg_pkg;

   typedef logic [2:0] seg_id_t;

   localparam seg_id_t seg_es = 3'd0;
   localparam seg_id_t seg_cs = 3'd1;
   localparam seg_id_t seg_ss = 3'd2;
   localparam seg_id_t seg_ds = 3'd3;
   localparam seg_id_t seg_fs = 3'd4;
   localparam seg_id_t seg_gs = 3'd5;

   localparam seg_id_t seg_stack = seg_ss;

   typedef logic [1:0] mem_size_t;

   localparam mem_size_t size_byte  = 2'd0;
   localparam mem_size_t size_word  = 2'd1;
   localparam mem_size_t size_dword = 2'd2;

   typedef struct packed {
      logic [15:0] base;
      logic [31:0] limit;
   } seg_desc_t;

   // Access size in bytes
   function automatic logic [2:0] size_bytes(mem_size_t size);
      case (size)
         size_byte: return 3'd1;
         size_word: return 3'd2;
         default:   return 3'd4;
      endcase
   endfunction

   function automatic logic [31:0] lin_addr(seg_desc_t desc, logic [31:0] off);
      return {desc.base, 16'h0000} + off;
   endfunction

endpackage

// ==== src/agen_pkg.sv ====
package agen_pkg;

   // Address source codes, shared by the read and write selects
   typedef logic [1:0] addr_sel_t;

   localparam addr_sel_t addr_seg1  = 2'd0;
   localparam addr_sel_t addr_stack = 2'd1;
   localparam addr_sel_t addr_intr  = 2'd2;
   localparam addr_sel_t addr_cmps  = 2'd3;

   // Control store fields used by this stage
   typedef struct packed {
      logic      mux_imm1;
      addr_sel_t rd_sel;
      addr_sel_t wr_sel;
      logic      repne_steady;
      logic      cmps_first;
      logic      cmps_second;
      logic      jmp_stall_de;
      logic      near_ret;
      logic      far_ret;
      logic      ld_flags;
      logic      df_affected;
   } agen_ctrl_t;

   typedef struct packed {
      logic                v;
      agen_ctrl_t          ctrl;
      logic [31:0]         neip;
      logic [31:0]         a;
      logic [31:0]         b;
      logic [31:0]         disp_off;
      logic [31:0]         sib_off;
      logic [31:0]         sp;
      logic [31:0]         intr_addr;
      seg_pkg::seg_id_t    seg1;
      seg_pkg::mem_size_t  mem_size;
      logic                mem_rd;
      logic                mem_wr;
      logic                df;
      logic                exc_en;
      logic                page_fault;
   } agen_in_t;

   typedef struct packed {
      logic                v;
      logic [31:0]         rd_addr;
      logic [31:0]         wr_addr;
      logic                mem_rd;
      logic                mem_wr;
      seg_pkg::mem_size_t  mem_size;
      logic                seg_exc;
      logic                page_fault;
   } ag_mem_t;

   typedef struct packed {
      logic        v;
      logic [31:0] neip;
      logic [31:0] a;
      logic [31:0] b;
   } ag_data_t;

endpackage

// ==== src/seg_regs.sv ====
`timescale 1ns/1ps

module seg_regs #(
   parameter int N_SEG = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               seg_wr_en,
   input  seg_pkg::seg_id_t   seg_wr_id,
   input  seg_pkg::seg_desc_t seg_wr_desc,
   input  seg_pkg::seg_id_t   access_seg,
   input  seg_pkg::seg_id_t   seg1,
   output seg_pkg::seg_desc_t access_desc,
   output seg_pkg::seg_desc_t seg1_desc,
   output seg_pkg::seg_desc_t ss_desc
);
   import seg_pkg::*;

   seg_desc_t seg_file [N_SEG];

   // Flat segments out of reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < N_SEG; i++) begin
            seg_file[i].base  <= 16'h0000;
            seg_file[i].limit <= 32'hffff_ffff;
         end
      end else if (seg_wr_en) begin
         seg_file[seg_wr_id] <= seg_wr_desc;
      end
   end

   assign access_desc = seg_file[access_seg];
   assign seg1_desc   = seg_file[seg1];
   assign ss_desc     = seg_file[seg_stack];

endmodule

// ==== src/seg_limit_check.sv ====
`timescale 1ns/1ps

module seg_limit_check (
   input  logic                v,
   input  logic                exc_en,
   input  logic                mem_rd,
   input  logic                mem_wr,
   input  agen_pkg::addr_sel_t rd_sel,
   input  agen_pkg::addr_sel_t wr_sel,
   input  seg_pkg::mem_size_t  mem_size,
   input  logic [31:0]         rd_off,
   input  logic [31:0]         wr_off,
   input  logic [31:0]         rd_limit,
   input  logic [31:0]         wr_limit,
   output logic                seg_exc
);
   import agen_pkg::*;
   import seg_pkg::*;

   logic [2:0]  nbytes;
   logic [32:0] rd_last;
   logic [32:0] wr_last;
   logic        rd_fault;
   logic        wr_fault;

   assign nbytes = size_bytes(mem_size);

   // Address of the last byte touched, one extra bit for the carry
   assign rd_last = {1'b0, rd_off} + {30'd0, nbytes} - 33'd1;
   assign wr_last = {1'b0, wr_off} + {30'd0, nbytes} - 33'd1;

   // Vector fetches have no segment
   assign rd_fault = mem_rd && (rd_sel != addr_intr) && (rd_last > {1'b0, rd_limit});
   assign wr_fault = mem_wr && (wr_sel != addr_intr) && (wr_last > {1'b0, wr_limit});

   assign seg_exc = v && !exc_en && (rd_fault || wr_fault);

endmodule

// ==== src/cmps_addr_track.sv ====
`timescale 1ns/1ps

module cmps_addr_track (
   input  logic               clk,
   input  logic               reset,
   input  logic               upd,
   input  logic [31:0]        a,
   input  seg_pkg::seg_id_t   seg1,
   input  logic               df,
   input  seg_pkg::mem_size_t mem_size,
   input  logic               repne_steady,
   input  logic               cmps_first,
   input  logic               cmps_second,
   output logic [31:0]        cmps_off,
   output seg_pkg::seg_id_t   cmps_seg
);
   import seg_pkg::*;

   logic [31:0] esi_off;
   logic [31:0] edi_off;
   seg_id_t     esi_seg;
   seg_id_t     edi_seg;
   logic [31:0] step;
   logic [31:0] saved_off;
   seg_id_t     saved_seg;
   logic [31:0] next_off;

   // Step is the access size, negative when df is set
   assign step = df ? -{29'd0, size_bytes(mem_size)} : {29'd0, size_bytes(mem_size)};

   // Second micro-op works on the EDI pair
   assign saved_off = cmps_second ? edi_off : esi_off;
   assign saved_seg = cmps_second ? edi_seg : esi_seg;

   assign next_off = (repne_steady ? saved_off : a) + step;

   // First pass reads at a itself
   assign cmps_off = repne_steady ? next_off : a;
   assign cmps_seg = repne_steady ? saved_seg : seg1;

   always_ff @(posedge clk) begin
      if (reset) begin
         esi_off <= '0;
         edi_off <= '0;
         esi_seg <= '0;
         edi_seg <= '0;
      end else if (upd) begin
         if (cmps_first) begin
            esi_off <= next_off;
            esi_seg <= cmps_seg;
         end
         if (cmps_second) begin
            edi_off <= next_off;
            edi_seg <= cmps_seg;
         end
      end
   end

endmodule

// ==== src/pipe_latch.sv ====
`timescale 1ns/1ps

module pipe_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     stall,
   input  payload_t d,
   output payload_t q
);

   // Holds its contents while the next stage stalls
   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// ==== src/agen_stage2.sv ====
`timescale 1ns/1ps

module agen_stage2 (
   input  logic               clk,
   input  logic               reset,
   input  logic               stall,
   input  agen_pkg::agen_in_t ag_in,
   input  seg_pkg::seg_desc_t access_desc,
   input  seg_pkg::seg_desc_t seg1_desc,
   input  seg_pkg::seg_desc_t ss_desc,
   output seg_pkg::seg_id_t   access_seg,
   output seg_pkg::seg_id_t   seg1,
   output agen_pkg::ag_mem_t  mem_next,
   output agen_pkg::ag_data_t data_next,
   output logic               jmp_stall,
   output logic               v_ld_df
);
   import agen_pkg::*;
   import seg_pkg::*;

   logic [31:0] seg1_off;
   logic [31:0] cmps_off;
   seg_id_t     cmps_seg;
   logic [31:0] rd_off;
   logic [31:0] wr_off;
   seg_desc_t   rd_desc;
   seg_desc_t   wr_desc;
   logic        seg_exc;

   assign seg1_off = ag_in.disp_off + ag_in.sib_off;

   cmps_addr_track u_cmps (
      .clk          (clk),
      .reset        (reset),
      .upd          (ag_in.v && !stall),
      .a            (ag_in.a),
      .seg1         (ag_in.seg1),
      .df           (ag_in.df),
      .mem_size     (ag_in.mem_size),
      .repne_steady (ag_in.ctrl.repne_steady),
      .cmps_first   (ag_in.ctrl.cmps_first),
      .cmps_second  (ag_in.ctrl.cmps_second),
      .cmps_off     (cmps_off),
      .cmps_seg     (cmps_seg)
   );

   assign seg1       = ag_in.seg1;
   assign access_seg = (ag_in.ctrl.rd_sel == addr_cmps) ? cmps_seg : ag_in.seg1;

   // Read source select, intr offset unused
   always_comb begin
      case (ag_in.ctrl.rd_sel)
         addr_seg1:  begin rd_off = seg1_off; rd_desc = seg1_desc;   end
         addr_stack: begin rd_off = ag_in.sp; rd_desc = ss_desc;     end
         addr_intr:  begin rd_off = seg1_off; rd_desc = seg1_desc;   end
         default:    begin rd_off = cmps_off; rd_desc = access_desc; end
      endcase
   end

   // Writes only go through seg1 or the stack
   assign wr_off  = (ag_in.ctrl.wr_sel == addr_stack) ? ag_in.sp : seg1_off;
   assign wr_desc = (ag_in.ctrl.wr_sel == addr_stack) ? ss_desc : seg1_desc;

   seg_limit_check u_limit (
      .v        (ag_in.v),
      .exc_en   (ag_in.exc_en),
      .mem_rd   (ag_in.mem_rd),
      .mem_wr   (ag_in.mem_wr),
      .rd_sel   (ag_in.ctrl.rd_sel),
      .wr_sel   (ag_in.ctrl.wr_sel),
      .mem_size (ag_in.mem_size),
      .rd_off   (rd_off),
      .wr_off   (wr_off),
      .rd_limit (rd_desc.limit),
      .wr_limit (wr_desc.limit),
      .seg_exc  (seg_exc)
   );

   always_comb begin
      mem_next.v          = ag_in.v;
      mem_next.rd_addr    = (ag_in.ctrl.rd_sel == addr_intr) ? ag_in.intr_addr
                                                             : lin_addr(rd_desc, rd_off);
      mem_next.wr_addr    = lin_addr(wr_desc, wr_off);
      mem_next.mem_rd     = ag_in.mem_rd;
      mem_next.mem_wr     = ag_in.mem_wr;
      mem_next.mem_size   = ag_in.mem_size;
      mem_next.seg_exc    = seg_exc;
      mem_next.page_fault = ag_in.page_fault;
   end

   always_comb begin
      data_next.v    = ag_in.v;
      data_next.neip = ag_in.neip;
      data_next.a    = ag_in.a;
      data_next.b    = ag_in.ctrl.mux_imm1 ? 32'd1 : ag_in.b;
   end

   assign jmp_stall = ag_in.v &&
                      (ag_in.ctrl.jmp_stall_de || ag_in.ctrl.near_ret || ag_in.ctrl.far_ret);
   assign v_ld_df   = ag_in.v && ag_in.ctrl.ld_flags && ag_in.ctrl.df_affected;

endmodule

// ==== src/agen_top.sv ====
`timescale 1ns/1ps

module agen_top #(
   parameter int N_SEG = 8
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               stall,
   input  agen_pkg::agen_in_t ag_in,
   input  logic               seg_wr_en,
   input  seg_pkg::seg_id_t   seg_wr_id,
   input  seg_pkg::seg_desc_t seg_wr_desc,
   output agen_pkg::ag_mem_t  mem_out,
   output agen_pkg::ag_data_t data_out,
   output logic               jmp_stall,
   output logic               v_ld_df
);
   import agen_pkg::*;
   import seg_pkg::*;

   seg_id_t   access_seg;
   seg_id_t   seg1;
   seg_desc_t access_desc;
   seg_desc_t seg1_desc;
   seg_desc_t ss_desc;
   ag_mem_t   mem_next;
   ag_data_t  data_next;

   seg_regs #(.N_SEG(N_SEG)) u_seg_regs (
      .clk         (clk),
      .reset       (reset),
      .seg_wr_en   (seg_wr_en),
      .seg_wr_id   (seg_wr_id),
      .seg_wr_desc (seg_wr_desc),
      .access_seg  (access_seg),
      .seg1        (seg1),
      .access_desc (access_desc),
      .seg1_desc   (seg1_desc),
      .ss_desc     (ss_desc)
   );

   agen_stage2 u_stage2 (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .ag_in       (ag_in),
      .access_desc (access_desc),
      .seg1_desc   (seg1_desc),
      .ss_desc     (ss_desc),
      .access_seg  (access_seg),
      .seg1        (seg1),
      .mem_next    (mem_next),
      .data_next   (data_next),
      .jmp_stall   (jmp_stall),
      .v_ld_df     (v_ld_df)
   );

   pipe_latch #(.payload_t(ag_mem_t)) u_mem_latch (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .d     (mem_next),
      .q     (mem_out)
   );

   pipe_latch #(.payload_t(ag_data_t)) u_data_latch (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .d     (data_next),
      .q     (data_out)
   );

endmodule

// ==== test/agen_vectors.svh ====
// Row: stall, v, ctrl, a, disp_off, sib_off, sp, intr_addr, seg1, mem_size,
//      mem_rd, mem_wr, df, exc_en, expected rd_addr, wr_addr, seg_exc,
//      expected B is one, jmp_stall, v_ld_df
// ctrl bits: mux_imm1 _ rd_sel _ wr_sel _ steady/first/second _ jsde/near/far/ld/df_aff

typedef struct {
   logic     stall;
   agen_in_t in;
   ag_mem_t  exp_mem;
   ag_data_t exp_data;
   logic     exp_js;
   logic     exp_ldf;
} vec_t;

vec_t vecs[$];

task automatic add_row(input logic stall, input logic v, input agen_ctrl_t ctrl,
                       input logic [31:0] a, input logic [31:0] disp,
                       input logic [31:0] sib, input logic [31:0] sp,
                       input logic [31:0] intr, input seg_id_t seg1, input mem_size_t size,
                       input logic rd, input logic wr, input logic df, input logic exc_en,
                       input logic [31:0] exp_rd, input logic [31:0] exp_wr,
                       input logic exp_exc, input logic exp_b1, input logic exp_js,
                       input logic exp_ldf);
   vec_t        row;
   logic [31:0] rnd;
   rnd = $urandom();
   row.stall = stall;
   row.in = '0;
   row.in.v = v;
   row.in.ctrl = ctrl;
   row.in.neip = $urandom();
   row.in.a = a;
   row.in.b = $urandom();
   row.in.disp_off = disp;
   row.in.sib_off = sib;
   row.in.sp = sp;
   row.in.intr_addr = intr;
   row.in.seg1 = seg1;
   row.in.mem_size = size;
   row.in.mem_rd = rd;
   row.in.mem_wr = wr;
   row.in.df = df;
   row.in.exc_en = exc_en;
   row.in.page_fault = rnd[0];
   row.exp_mem.v = v;
   row.exp_mem.rd_addr = exp_rd;
   row.exp_mem.wr_addr = exp_wr;
   row.exp_mem.mem_rd = rd;
   row.exp_mem.mem_wr = wr;
   row.exp_mem.mem_size = size;
   row.exp_mem.seg_exc = exp_exc;
   row.exp_mem.page_fault = rnd[0];
   row.exp_data.v = v;
   row.exp_data.neip = row.in.neip;
   row.exp_data.a = a;
   // Expected B is either one or the driven value
   row.exp_data.b = exp_b1 ? 32'd1 : row.in.b;
   row.exp_js = exp_js;
   row.exp_ldf = exp_ldf;
   vecs.push_back(row);
endtask

task automatic load_vectors();
   // Plain sources, limits and strobes
   add_row('0, '1, 13'b0_00_00_000_00000, 'h0, 'h100, 'h20, 'h0, 'h0, seg_ds, size_dword,
           '1, '0, '0, '0, 'h0010_0120, 'h0010_0120, '0, '0, '0, '0);
   add_row('0, '1, 13'b1_01_01_000_10000, 'h0, 'h10, 'h0, 'h200, 'h0, seg_ds, size_word,
           '1, '1, '0, '0, 'h0020_0200, 'h0020_0200, '0, '1, '1, '0);
   add_row('0, '1, 13'b0_10_00_000_01000, 'h0, 'h2000, 'h0, 'h0, 'hfee0_0008, seg_ds,
           size_byte, '1, '0, '0, '0, 'hfee0_0008, 'h0010_2000, '0, '0, '1, '0);
   add_row('0, '1, 13'b0_00_00_000_00011, 'h0, 'hff0, 'h0f, 'h0, 'h0, seg_ds, size_byte,
           '1, '0, '0, '0, 'h0010_0fff, 'h0010_0fff, '0, '0, '0, '1);
   add_row('0, '1, 13'b0_00_00_000_00100, 'h0, 'hffd, 'h0, 'h0, 'h0, seg_ds, size_dword,
           '1, '0, '0, '0, 'h0010_0ffd, 'h0010_0ffd, '1, '0, '1, '0);
   add_row('0, '1, 13'b0_00_00_000_00010, 'h0, 'hffd, 'h0, 'h0, 'h0, seg_ds, size_dword,
           '1, '0, '0, '1, 'h0010_0ffd, 'h0010_0ffd, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_00_00_000_00000, 'h0, 'hffd, 'h0, 'h0, 'h0, seg_ds, size_dword,
           '0, '0, '0, '0, 'h0010_0ffd, 'h0010_0ffd, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_00_01_000_00000, 'h0, 'h40, 'h0, 'hfffe, 'h0, seg_ds, size_dword,
           '0, '1, '0, '0, 'h0010_0040, 'h0020_fffe, '1, '0, '0, '0);
   add_row('0, '0, 13'b0_00_00_000_11111, 'h0, 'hffd, 'h0, 'h0, 'h0, seg_ds, size_dword,
           '1, '0, '0, '0, 'h0010_0ffd, 'h0010_0ffd, '0, '0, '0, '0);
   // REPNE CMPS, df 0, word
   add_row('0, '1, 13'b0_11_00_010_00000, 'h100, 'h0, 'h0, 'h0, 'h0, seg_ds, size_word,
           '1, '0, '0, '0, 'h0010_0100, 'h0010_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_001_00000, 'h2000, 'h0, 'h0, 'h0, 'h0, seg_es, size_word,
           '1, '0, '0, '0, 'h0030_2000, 'h0030_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_110_00000, 'h5555, 'h0, 'h0, 'h0, 'h0, seg_gs, size_word,
           '1, '0, '0, '0, 'h0010_0104, 'h0000_0000, '0, '0, '0, '0);
   add_row('1, '1, 13'b0_11_00_101_00000, 'h6666, 'h0, 'h0, 'h0, 'h0, seg_gs, size_word,
           '1, '0, '0, '0, 'h0030_2004, 'h0000_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_101_00000, 'h6666, 'h0, 'h0, 'h0, 'h0, seg_gs, size_word,
           '1, '0, '0, '0, 'h0030_2004, 'h0000_0000, '0, '0, '0, '0);
   // REPNE CMPS, df 1, dword
   add_row('0, '1, 13'b0_11_00_010_00000, 'h3000, 'h0, 'h0, 'h0, 'h0, seg_es, size_dword,
           '1, '0, '1, '0, 'h0030_3000, 'h0030_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_001_00000, 'h800, 'h0, 'h0, 'h0, 'h0, seg_ds, size_dword,
           '1, '0, '1, '0, 'h0010_0800, 'h0010_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_110_00000, 'h0, 'h0, 'h0, 'h0, 'h0, seg_gs, size_dword,
           '1, '0, '1, '0, 'h0030_2ff8, 'h0000_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_101_00000, 'h0, 'h0, 'h0, 'h0, 'h0, seg_gs, size_dword,
           '1, '0, '1, '0, 'h0010_07f8, 'h0000_0000, '0, '0, '0, '0);
   add_row('1, '1, 13'b0_11_00_110_00000, 'h0, 'h0, 'h0, 'h0, 'h0, seg_gs, size_dword,
           '1, '0, '1, '0, 'h0030_2ff4, 'h0000_0000, '0, '0, '0, '0);
   add_row('0, '1, 13'b0_11_00_110_00000, 'h0, 'h0, 'h0, 'h0, 'h0, seg_gs, size_dword,
           '1, '0, '1, '0, 'h0030_2ff4, 'h0000_0000, '0, '0, '0, '0);
endtask

// ==== test/agen_tb.sv ====
`timescale 1ns/1ps

module agen_tb;
   import agen_pkg::*;
   import seg_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;

   logic      clk;
   logic      reset;
   logic      stall;
   agen_in_t  ag_in;
   logic      seg_wr_en;
   seg_id_t   seg_wr_id;
   seg_desc_t seg_wr_desc;
   ag_mem_t   mem_out;
   ag_data_t  data_out;
   logic      jmp_stall;
   logic      v_ld_df;
   ag_mem_t   exp_mem;
   ag_data_t  exp_data;
   int        errors;
   int        n_rows;

   `include "agen_vectors.svh"

   agen_top #(.N_SEG(8)) i_agen_top (
      .clk         (clk),
      .reset       (reset),
      .stall       (stall),
      .ag_in       (ag_in),
      .seg_wr_en   (seg_wr_en),
      .seg_wr_id   (seg_wr_id),
      .seg_wr_desc (seg_wr_desc),
      .mem_out     (mem_out),
      .data_out    (data_out),
      .jmp_stall   (jmp_stall),
      .v_ld_df     (v_ld_df)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_val(input string name, input logic [127:0] got,
                            input logic [127:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("Fail %s at %0t got %h exp %h", name, $time, got, exp);
      end
   endtask

   task automatic check_strobes(input logic exp_js, input logic exp_ldf);
      check_val("jmp_stall", jmp_stall, exp_js);
      check_val("v_ld_df", v_ld_df, exp_ldf);
   endtask

   task automatic write_seg(input seg_id_t id, input logic [15:0] base,
                            input logic [31:0] limit);
      @(posedge clk);
      seg_wr_en <= 1'b1;
      seg_wr_id <= id;
      seg_wr_desc <= '{base: base, limit: limit};
   endtask

   // Time limit from the row count
   initial begin
      wait (n_rows > 0);
      #(CLK_PERIOD * (n_rows + RESET_CYCLES + 20));
      $display("Timeout: the test loop did not complete in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      stall = 1'b0;
      ag_in = '0;
      // Valid faulting read held on the inputs through reset
      ag_in.v = 1'b1;
      ag_in.mem_rd = 1'b1;
      ag_in.disp_off = 32'hffff_fffd;
      ag_in.mem_size = size_dword;
      seg_wr_en = 1'b0;
      seg_wr_id = '0;
      seg_wr_desc = '0;
      exp_mem = '0;
      exp_data = '0;
      errors = 0;
      n_rows = 0;
      void'($urandom(70));
      load_vectors();
      n_rows = vecs.size();

      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      ag_in <= '0;
      @(negedge clk);
      check_val("mem_out.v", mem_out.v, 1'b0);
      check_val("data_out.v", data_out.v, 1'b0);
      check_val("mem_out.seg_exc", mem_out.seg_exc, 1'b0);

      write_seg(seg_ds, 16'h0010, 32'h0000_0fff);
      write_seg(seg_ss, 16'h0020, 32'h0000_ffff);
      write_seg(seg_es, 16'h0030, 32'h0001_0000);
      @(posedge clk);
      seg_wr_en <= 1'b0;

      // Outputs of row i-1 are checked while row i is on the inputs
      for (int i = 0; i <= n_rows; i++) begin
         @(posedge clk);
         if (i < n_rows) begin
            stall <= vecs[i].stall;
            ag_in <= vecs[i].in;
         end else begin
            stall <= 1'b0;
            ag_in <= '0;
         end
         @(negedge clk);
         if (i < n_rows) begin
            check_strobes(vecs[i].exp_js, vecs[i].exp_ldf);
         end
         if (i > 0) begin
            // Stalled row leaves the latches holding
            if (!vecs[i - 1].stall) begin
               exp_mem = vecs[i - 1].exp_mem;
               exp_data = vecs[i - 1].exp_data;
            end
            check_val("mem_out", mem_out, exp_mem);
            check_val("data_out", data_out, exp_data);
         end
      end

      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+test
src/seg_pkg.sv
src/agen_pkg.sv
src/seg_regs.sv
src/seg_limit_check.sv
src/cmps_addr_track.sv
src/pipe_latch.sv
src/agen_stage2.sv
src/agen_top.sv
test/agen_tb.sv
